// ==== src.f ====
hdl/soc_pkg.sv
hdl/axil_native_bridge.sv
hdl/native_interconnect.sv
hdl/sram_bank.sv
hdl/uart_periph.sv
hdl/reset_ctrl.sv
hdl/soc_top.sv
sim/soc_checker.sv
sim/soc_tb.sv

// ==== sim/soc_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module soc_tb;

   // cycles allowed for any single wait
   localparam int WAIT_LIMIT = 200;

   logic               clk;
   logic               reset;
   soc_pkg::axil_req_t axil_req;
   soc_pkg::axil_rsp_t axil_rsp;
   wire                ser_tx;
   wire                ser_rx;
   wire                core_reset;
   wire                mem_remap;

   int unsigned errors;
   int unsigned timeouts;
   logic        timed_out;

   // shadow of main memory
   soc_pkg::word_t main_model [soc_pkg::MAIN_WORDS];

   // uart looped back on itself
   assign ser_rx = ser_tx;

   soc_top dut0 (
      .clk        (clk),
      .reset      (reset),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .ser_tx     (ser_tx),
      .ser_rx     (ser_rx),
      .core_reset (core_reset),
      .mem_remap  (mem_remap)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////
   // inputs change and outputs are read 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t: no %s from the DUT", $time, what);
      timeouts++;
      timed_out = 1'b1;
   endtask

   function automatic soc_pkg::word_t word_addr(input logic [1:0] region, input int idx);
      soc_pkg::soc_addr_u a;
      a.raw          = '0;
      a.f.region     = region;
      a.f.word_index = idx[11:0];
      return a.raw;
   endfunction

   function automatic soc_pkg::word_t uart_addr(input logic [3:0] ofs);
      return {soc_pkg::REGION_UART, 26'd0, ofs};
   endfunction

   // fill patterns over the whole address
   function automatic soc_pkg::word_t main_pattern(input soc_pkg::word_t addr);
      return {addr[15:0], addr[31:16]} ^ 32'h3C3C_A5A5;
   endfunction

   function automatic soc_pkg::word_t boot_pattern(input soc_pkg::word_t addr);
      return addr ^ 32'hC0DE_5A00;
   endfunction

   // strobed byte lanes replace the old word
   function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old_w,
                                                 input soc_pkg::word_t new_w,
                                                 input soc_pkg::strb_t strb);
      soc_pkg::word_t w;
      w = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            w[8*b +: 8] = new_w[8*b +: 8];
      end
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic check_word(input soc_pkg::word_t got, input soc_pkg::word_t exp,
                             input string msg);
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string msg);
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t: %s, response %b, expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // axi4-lite master
   //////////////////////////////////////////////////////////////////////
   task automatic axil_write(input soc_pkg::word_t addr, input soc_pkg::word_t data,
                             input soc_pkg::strb_t strb, input int bdelay,
                             output logic [1:0] resp);
      int n;
      resp = 'x;
      if (timed_out)
         return;
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = strb;
      for (n = 0; n < WAIT_LIMIT && !axil_rsp.awready; n++)
         next_cycle();
      if (!axil_rsp.awready) begin
         report_timeout("awready");
         return;
      end
      // aw and w taken in the same cycle
      check_bit(axil_rsp.wready, 1'b1, "wready with awready");
      // accepted on this edge
      next_cycle();
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !axil_rsp.bvalid; n++)
         next_cycle();
      if (!axil_rsp.bvalid) begin
         report_timeout("bvalid");
         return;
      end
      // master back-pressure
      repeat (bdelay) next_cycle();
      resp = axil_rsp.bresp;
      axil_req.bready = 1'b1;
      next_cycle();
      axil_req.bready = 1'b0;
   endtask

   // lat counts cycles from arready seen to rvalid seen
   task automatic axil_read(input soc_pkg::word_t addr, input int rdelay,
                            output soc_pkg::word_t data, output logic [1:0] resp,
                            output int lat);
      int n;
      data = 'x;
      resp = 'x;
      lat  = 0;
      if (timed_out)
         return;
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      for (n = 0; n < WAIT_LIMIT && !axil_rsp.arready; n++)
         next_cycle();
      if (!axil_rsp.arready) begin
         report_timeout("arready");
         return;
      end
      next_cycle();
      axil_req.arvalid = 1'b0;
      lat = 1;
      for (n = 0; n < WAIT_LIMIT && !axil_rsp.rvalid; n++) begin
         next_cycle();
         lat++;
      end
      if (!axil_rsp.rvalid) begin
         report_timeout("rvalid");
         return;
      end
      repeat (rdelay) next_cycle();
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      axil_req.rready = 1'b1;
      next_cycle();
      axil_req.rready = 1'b0;
   endtask

   // width of the next core reset pulse
   task automatic measure_pulse(output int width);
      int n;
      width = 0;
      for (n = 0; n < WAIT_LIMIT && !core_reset; n++)
         next_cycle();
      if (!core_reset) begin
         report_timeout("core reset pulse");
         return;
      end
      while (core_reset && width < WAIT_LIMIT) begin
         width++;
         next_cycle();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////
   // por hold counted from reset release
   task automatic test_reset();
      int             n;
      int             lat;
      soc_pkg::word_t got;
      logic [1:0]     resp;
      for (n = 0; n < WAIT_LIMIT && core_reset; n++)
         next_cycle();
      if (core_reset) begin
         report_timeout("core reset release");
         return;
      end
      check_word(32'(n), 32'(soc_pkg::POR_CYCLES), "power-on hold length");
      check_bit(mem_remap, 1'b0, "mem_remap after reset");
      axil_read(soc_pkg::CTRL_REMAP_ADDR, 0, got, resp, lat);
      check_word(got, 32'd0, "remap register after reset");
      check_resp(resp, soc_pkg::RESP_OKAY, "remap register read");
   endtask

   task automatic test_main_mem();
      soc_pkg::strb_t strb_list [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'h6};
      soc_pkg::word_t addr;
      soc_pkg::word_t data;
      soc_pkg::word_t got;
      logic [1:0]     resp;
      int             lat;
      for (int i = 0; i < 8; i++) begin
         addr = word_addr(soc_pkg::REGION_MAIN, 16 + i);
         axil_write(addr, main_pattern(addr), 4'hF, 0, resp);
         check_resp(resp, soc_pkg::RESP_OKAY, "main full write");
         main_model[16 + i] = main_pattern(addr);
         // partial write over it
         data = $urandom;
         axil_write(addr, data, strb_list[i], i % 3, resp);
         check_resp(resp, soc_pkg::RESP_OKAY, "main strobed write");
         main_model[16 + i] = merge_bytes(main_model[16 + i], data, strb_list[i]);
      end
      for (int i = 0; i < 8; i++) begin
         addr = word_addr(soc_pkg::REGION_MAIN, 16 + i);
         axil_read(addr, 0, got, resp, lat);
         check_word(got, main_model[16 + i], "main read data");
         check_resp(resp, soc_pkg::RESP_OKAY, "main read");
         check_word(32'(lat), 32'd3, "read latency");
      end
   endtask

   task automatic test_remap();
      soc_pkg::word_t addr;
      soc_pkg::word_t got;
      logic [1:0]     resp;
      int             lat;
      int             width;
      // same word offsets in both regions
      for (int k = 40; k < 44; k++) begin
         addr = word_addr(soc_pkg::REGION_CODE, k);
         axil_write(addr, boot_pattern(addr), 4'hF, 0, resp);
         check_resp(resp, soc_pkg::RESP_OKAY, "boot write");
         addr = word_addr(soc_pkg::REGION_MAIN, k);
         axil_write(addr, main_pattern(addr), 4'hF, 0, resp);
         check_resp(resp, soc_pkg::RESP_OKAY, "main write");
         main_model[k] = main_pattern(addr);
      end
      for (int k = 40; k < 44; k++) begin
         addr = word_addr(soc_pkg::REGION_CODE, k);
         axil_read(addr, 0, got, resp, lat);
         check_word(got, boot_pattern(addr), "region 0 before remap");
      end
      fork
         axil_write(soc_pkg::CTRL_REMAP_ADDR, 32'h1, 4'hF, 0, resp);
         measure_pulse(width);
      join
      check_resp(resp, soc_pkg::RESP_OKAY, "remap write");
      check_word(32'(width), 32'(soc_pkg::CORE_RESET_CYCLES), "core reset pulse width");
      check_bit(mem_remap, 1'b1, "mem_remap after remap write");
      // region 0 now aliases main memory
      for (int k = 40; k < 44; k++) begin
         axil_read(word_addr(soc_pkg::REGION_CODE, k), 1, got, resp, lat);
         check_word(got, main_model[k], "region 0 after remap");
      end
      axil_read(soc_pkg::CTRL_REMAP_ADDR, 0, got, resp, lat);
      check_word(got, 32'd1, "remap register after remap");
   endtask

   task automatic test_uart_loopback();
      logic [7:0]     tx_byte;
      soc_pkg::word_t stat;
      soc_pkg::word_t got;
      logic [1:0]     resp;
      int             lat;
      int             n;
      tx_byte = 8'($urandom);
      axil_write(uart_addr(soc_pkg::UART_DIV), 32'd4, 4'hF, 0, resp);
      axil_read(uart_addr(soc_pkg::UART_DIV), 0, got, resp, lat);
      check_word(got, 32'd4, "uart divisor readback");
      axil_write(uart_addr(soc_pkg::UART_DATA), {24'd0, tx_byte}, 4'h1, 0, resp);
      check_resp(resp, soc_pkg::RESP_OKAY, "uart data write");
      // poll for the looped-back byte
      stat = '0;
      for (n = 0; n < 60 && !stat[1]; n++)
         axil_read(uart_addr(soc_pkg::UART_STAT), 0, stat, resp, lat);
      if (stat[1] !== 1'b1) begin
         report_timeout("uart receive flag");
         return;
      end
      axil_read(uart_addr(soc_pkg::UART_DATA), 0, got, resp, lat);
      check_word(got, {24'd0, tx_byte}, "uart received byte");
      axil_read(uart_addr(soc_pkg::UART_STAT), 0, stat, resp, lat);
      check_bit(stat[1], 1'b0, "rx_valid after data read");
   endtask

   task automatic test_random_stress();
      soc_pkg::word_t addr;
      soc_pkg::word_t data;
      soc_pkg::word_t got;
      soc_pkg::strb_t strb;
      logic [1:0]     resp;
      int             idx;
      int             lat;
      // window of 64 words, filled first
      for (int i = 256; i < 320; i++) begin
         addr = word_addr(soc_pkg::REGION_MAIN, i);
         axil_write(addr, main_pattern(addr), 4'hF, 0, resp);
         main_model[i] = main_pattern(addr);
      end
      for (int i = 0; i < 200; i++) begin
         idx  = 256 + int'($urandom % 64);
         addr = word_addr(soc_pkg::REGION_MAIN, idx);
         if ($urandom % 2) begin
            data = $urandom;
            strb = 4'($urandom);
            axil_write(addr, data, strb, int'($urandom % 4), resp);
            check_resp(resp, soc_pkg::RESP_OKAY, "stress write");
            main_model[idx] = merge_bytes(main_model[idx], data, strb);
         end else begin
            axil_read(addr, int'($urandom % 4), got, resp, lat);
            check_word(got, main_model[idx], "stress read data");
            check_resp(resp, soc_pkg::RESP_OKAY, "stress read");
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      axil_req  = '0;
      reset     = 1'b1;
      errors    = 0;
      timeouts  = 0;
      timed_out = 1'b0;
      void'($urandom(32'h69a3));
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      test_reset();
      test_main_mem();
      test_remap();
      test_uart_loopback();
      test_random_stress();

      $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, dut0.bridge0.chk0.fail_count);
      if (errors == 0 && timeouts == 0 && dut0.bridge0.chk0.fail_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/soc_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module soc_checker (
   input wire                clk,
   input wire                reset,
   input soc_pkg::axil_req_t axil_req,
   input soc_pkg::axil_rsp_t axil_rsp,
   input soc_pkg::nat_req_t  nat_req,
   input soc_pkg::nat_rsp_t  nat_rsp
);

   // read by the testbench at the end of the run
   int unsigned fail_count = 0;

   //////////////////////////////////////////////////////////////////////
   // axi response channels
   //////////////////////////////////////////////////////////////////////
   // write response held until bready
   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else begin
         $error("bvalid dropped before bready");
         fail_count++;
      end

   // read data held with rvalid
   a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
      else begin
         $error("rvalid or rdata changed before rready");
         fail_count++;
      end

   //////////////////////////////////////////////////////////////////////
   // native bus
   //////////////////////////////////////////////////////////////////////
   a_nat_hold: assert property (@(posedge clk) disable iff (reset)
      nat_req.valid && !nat_rsp.ready |=> nat_req.valid && $stable(nat_req.addr.raw)
         && $stable(nat_req.wdata) && $stable(nat_req.wstrb))
      else begin
         $error("native request changed before ready");
         fail_count++;
      end

   // slave answers only a live request
   a_ready_in_valid: assert property (@(posedge clk) disable iff (reset)
      nat_rsp.ready |-> nat_req.valid)
      else begin
         $error("native ready without valid");
         fail_count++;
      end

endmodule

bind axil_native_bridge soc_checker chk0 (
   .clk      (clk),
   .reset    (reset),
   .axil_req (axil_req),
   .axil_rsp (axil_rsp),
   .nat_req  (nat_req),
   .nat_rsp  (nat_rsp)
);

`default_nettype wire

// ==== hdl/soc_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module soc_top (
   input  wire                clk,
   input  wire                reset,
   input  soc_pkg::axil_req_t axil_req,
   output soc_pkg::axil_rsp_t axil_rsp,
   output logic               ser_tx,
   input  wire                ser_rx,
   output logic               core_reset,
   output logic               mem_remap
);

   // stretched reset for everything behind the bridge
   logic sys_reset;

   // bridge side of the interconnect
   soc_pkg::nat_req_t m_req;
   soc_pkg::nat_rsp_t m_rsp;

   // one pair per slave region
   soc_pkg::nat_req_t code_req, main_req, uart_req, ctrl_req;
   soc_pkg::nat_rsp_t code_rsp, main_rsp, uart_rsp, ctrl_rsp;

   ////////////////////////////////////////////////////////////////////
   // master side
   ////////////////////////////////////////////////////////////////////
   // bridge sits where the core would be
   axil_native_bridge bridge0 (
      .clk      (clk),
      .reset    (sys_reset),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .nat_req  (m_req),
      .nat_rsp  (m_rsp)
   );

   native_interconnect xbar0 (
      .master_req (m_req),
      .master_rsp (m_rsp),
      .mem_remap  (mem_remap),
      .code_req   (code_req),
      .main_req   (main_req),
      .uart_req   (uart_req),
      .ctrl_req   (ctrl_req),
      .code_rsp   (code_rsp),
      .main_rsp   (main_rsp),
      .uart_rsp   (uart_rsp),
      .ctrl_rsp   (ctrl_rsp)
   );

   ////////////////////////////////////////////////////////////////////
   // slaves
   ////////////////////////////////////////////////////////////////////
   sram_bank #(.WORDS(soc_pkg::BOOT_WORDS)) boot_mem (
      .clk   (clk),
      .reset (sys_reset),
      .req   (code_req),
      .rsp   (code_rsp)
   );

   sram_bank #(.WORDS(soc_pkg::MAIN_WORDS)) main_mem (
      .clk   (clk),
      .reset (sys_reset),
      .req   (main_req),
      .rsp   (main_rsp)
   );

   uart_periph uart0 (
      .clk    (clk),
      .reset  (sys_reset),
      .req    (uart_req),
      .rsp    (uart_rsp),
      .ser_tx (ser_tx),
      .ser_rx (ser_rx)
   );

   // only block on the raw external reset
   reset_ctrl rstc0 (
      .clk        (clk),
      .reset      (reset),
      .req        (ctrl_req),
      .rsp        (ctrl_rsp),
      .sys_reset  (sys_reset),
      .core_reset (core_reset),
      .mem_remap  (mem_remap)
   );

endmodule

`default_nettype wire

// ==== hdl/reset_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module reset_ctrl (
   input  wire               clk,
   input  wire               reset,
   input  soc_pkg::nat_req_t req,
   output soc_pkg::nat_rsp_t rsp,
   output logic              sys_reset,
   output logic              core_reset,
   output logic              mem_remap
);

   logic [4:0]     por_cnt;
   logic [2:0]     core_cnt;
   logic           ready_q, acc, hit;
   soc_pkg::word_t rdata_q;

   assign acc = req.valid && !ready_q;
   assign hit = (req.addr.raw == soc_pkg::CTRL_REMAP_ADDR);

   ////////////////////////////////////////////////////////////////////
   // power-on hold
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         por_cnt   <= 5'd0;
         sys_reset <= 1'b1;
      end else if (sys_reset) begin
         // released after POR_CYCLES clean edges
         if (por_cnt == 5'(soc_pkg::POR_CYCLES - 1))
            sys_reset <= 1'b0;
         por_cnt <= por_cnt + 5'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // remap register and core reset pulse
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge sys_reset) begin
      if (sys_reset) begin
         ready_q   <= 1'b0;
         mem_remap <= 1'b0;
         core_cnt  <= 3'd0;
      end else begin
         ready_q <= req.valid && !ready_q;
         if (acc && |req.wstrb && hit) begin
            // sticky until next reset
            mem_remap <= 1'b1;
            core_cnt  <= 3'(soc_pkg::CORE_RESET_CYCLES);
         end else if (core_cnt != 3'd0) begin
            core_cnt <= core_cnt - 3'd1;
         end
      end
   end

   // other region 3 words read as zero
   always_ff @(posedge clk) begin
      if (acc)
         rdata_q <= hit ? {31'd0, mem_remap} : '0;
   end

   assign core_reset = sys_reset || (core_cnt != 3'd0);
   assign rsp.ready  = ready_q;
   assign rsp.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/uart_periph.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_periph (
   input  wire               clk,
   input  wire               reset,
   input  soc_pkg::nat_req_t req,
   output soc_pkg::nat_rsp_t rsp,
   output logic              ser_tx,
   input  wire               ser_rx
);

   logic           acc, wr, ready_q;
   logic [3:0]     ofs;
   soc_pkg::word_t rdata_q;
   logic [15:0]    div;
   // transmitter
   logic [9:0]     tx_shift;
   logic [3:0]     tx_bits;
   logic [15:0]    tx_clk;
   logic           tx_busy, tx_load;
   // receiver
   logic [1:0]     rx_sync;
   logic [3:0]     rx_bits;
   logic [15:0]    rx_cnt;
   logic [7:0]     rx_shift, rx_data;
   logic           rx_valid, rx_tick, rx_done, rd_data;

   // register access on the first valid cycle
   assign acc     = req.valid && !ready_q;
   assign wr      = |req.wstrb;
   assign ofs     = {req.addr.f.word_index[1:0], req.addr.f.byte_offset};
   assign tx_busy = (tx_bits != 4'd0);
   // writes to data while busy are dropped
   assign tx_load = acc && wr && (ofs == soc_pkg::UART_DATA) && !tx_busy;
   assign rd_data = acc && !wr && (ofs == soc_pkg::UART_DATA);
   assign rx_tick = (rx_bits != 4'd0) && (rx_cnt == 16'd0);
   // stop bit sampled high
   assign rx_done = rx_tick && (rx_bits == 4'd1) && rx_sync[1];

   ////////////////////////////////////////////////////////////////////
   // registers and 8n1 transmit
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q  <= 1'b0;
         div      <= soc_pkg::UART_DIV_RESET;
         tx_shift <= '1;
         tx_bits  <= 4'd0;
         tx_clk   <= 16'd0;
      end else begin
         ready_q <= req.valid && !ready_q;
         if (acc && wr && ofs == soc_pkg::UART_DIV)
            div <= req.wdata[15:0];
         if (tx_load) begin
            // stop, data lsb first, start
            tx_shift <= {1'b1, req.wdata[7:0], 1'b0};
            tx_bits  <= 4'd10;
            tx_clk   <= 16'd0;
         end else if (tx_busy) begin
            if (tx_clk == div - 16'd1) begin
               tx_clk   <= 16'd0;
               tx_shift <= {1'b1, tx_shift[9:1]};
               tx_bits  <= tx_bits - 4'd1;
            end else begin
               tx_clk <= tx_clk + 16'd1;
            end
         end
      end
   end

   // line idles high once all ones shifted in
   assign ser_tx = tx_shift[0];

   ////////////////////////////////////////////////////////////////////
   // receive, mid-bit sampling
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_sync  <= 2'b11;
         rx_bits  <= 4'd0;
         rx_cnt   <= 16'd0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], ser_rx};
         if (rx_bits == 4'd0) begin
            // start edge, wait half a bit
            if (!rx_sync[1]) begin
               rx_bits <= 4'd10;
               rx_cnt  <= (div - 16'd1) >> 1;
            end
         end else if (rx_cnt != 16'd0) begin
            rx_cnt <= rx_cnt - 16'd1;
         end else begin
            rx_cnt <= div - 16'd1;
            // glitch, start bit gone at mid-bit
            if (rx_bits == 4'd10 && rx_sync[1])
               rx_bits <= 4'd0;
            else
               rx_bits <= rx_bits - 4'd1;
         end
         // new byte overwrites an unread one
         if (rx_done)
            rx_valid <= 1'b1;
         else if (rd_data)
            rx_valid <= 1'b0;
      end
   end

   // data bits shift in lsb first
   always_ff @(posedge clk) begin
      if (rx_tick && rx_bits >= 4'd2 && rx_bits <= 4'd9)
         rx_shift <= {rx_sync[1], rx_shift[7:1]};
      if (rx_done)
         rx_data <= rx_shift;
      if (acc) begin
         case (ofs)
            soc_pkg::UART_DATA: rdata_q <= {24'd0, rx_data};
            soc_pkg::UART_DIV:  rdata_q <= {16'd0, div};
            soc_pkg::UART_STAT: rdata_q <= {30'd0, rx_valid, tx_busy};
            default:            rdata_q <= '0;
         endcase
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/sram_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module sram_bank #(
   parameter int WORDS = 1024
) (
   input  wire               clk,
   input  wire               reset,
   input  soc_pkg::nat_req_t req,
   output soc_pkg::nat_rsp_t rsp
);

   soc_pkg::word_t           mem [WORDS];
   soc_pkg::word_t           rdata_q;
   logic [$clog2(WORDS)-1:0] idx;
   logic                     ready_q;

   // word index wraps at the bank depth
   assign idx = req.addr.f.word_index[$clog2(WORDS)-1:0];

   // one ready per request, low again right after
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         ready_q <= 1'b0;
      else
         ready_q <= req.valid && !ready_q;
   end

   // byte lane writes and synchronous read
   always_ff @(posedge clk) begin
      if (req.valid && !ready_q) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b])
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
         end
         rdata_q <= mem[idx];
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/native_interconnect.sv ====
`default_nettype none
`timescale 1ns/1ps

module native_interconnect (
   input  soc_pkg::nat_req_t master_req,
   output soc_pkg::nat_rsp_t master_rsp,
   input  wire               mem_remap,
   output soc_pkg::nat_req_t code_req,
   output soc_pkg::nat_req_t main_req,
   output soc_pkg::nat_req_t uart_req,
   output soc_pkg::nat_req_t ctrl_req,
   input  soc_pkg::nat_rsp_t code_rsp,
   input  soc_pkg::nat_rsp_t main_rsp,
   input  soc_pkg::nat_rsp_t uart_rsp,
   input  soc_pkg::nat_rsp_t ctrl_rsp
);

   logic [1:0] region;

   // top two address bits pick the slave
   assign region = master_req.addr.f.region;

   ////////////////////////////////////////////////////////////////////
   // request fan-out and response mux
   ////////////////////////////////////////////////////////////////////
   always_comb begin
      // payload goes everywhere, valid only to one
      code_req       = master_req;
      main_req       = master_req;
      uart_req       = master_req;
      ctrl_req       = master_req;
      code_req.valid = 1'b0;
      main_req.valid = 1'b0;
      uart_req.valid = 1'b0;
      ctrl_req.valid = 1'b0;
      master_rsp     = '0;

      case (region)
         soc_pkg::REGION_CODE: begin
            // after remap region 0 aliases main memory
            if (mem_remap) begin
               main_req.valid = master_req.valid;
               master_rsp     = main_rsp;
            end else begin
               code_req.valid = master_req.valid;
               master_rsp     = code_rsp;
            end
         end
         // main memory has two sources, never live together
         soc_pkg::REGION_MAIN: begin
            main_req.valid = master_req.valid;
            master_rsp     = main_rsp;
         end
         soc_pkg::REGION_UART: begin
            uart_req.valid = master_req.valid;
            master_rsp     = uart_rsp;
         end
         default: begin
            ctrl_req.valid = master_req.valid;
            master_rsp     = ctrl_rsp;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/axil_native_bridge.sv ====
`default_nettype none
`timescale 1ns/1ps

module axil_native_bridge (
   input  wire                clk,
   input  wire                reset,
   input  soc_pkg::axil_req_t axil_req,
   output soc_pkg::axil_rsp_t axil_rsp,
   output soc_pkg::nat_req_t  nat_req,
   input  soc_pkg::nat_rsp_t  nat_rsp
);

   logic [1:0] state;
   // registered address channel readies
   logic aw_rdy;
   logic ar_rdy;
   logic is_write;
   logic aw_fire;
   logic ar_fire;

   // captured transaction
   soc_pkg::soc_addr_u req_addr;
   soc_pkg::word_t     req_wdata;
   soc_pkg::strb_t     req_wstrb;
   soc_pkg::word_t     rsp_rdata;

   // master keeps valid up while ready is high
   assign aw_fire = aw_rdy && axil_req.awvalid && axil_req.wvalid;
   assign ar_fire = ar_rdy && axil_req.arvalid;

   ////////////////////////////////////////////////////////////////////
   // control fsm
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= soc_pkg::ST_IDLE;
         aw_rdy   <= 1'b0;
         ar_rdy   <= 1'b0;
         is_write <= 1'b0;
      end else begin
         case (state)
            soc_pkg::ST_IDLE: begin
               aw_rdy <= 1'b0;
               ar_rdy <= 1'b0;
               if (aw_fire) begin
                  state    <= soc_pkg::ST_REQ;
                  is_write <= 1'b1;
               end else if (ar_fire) begin
                  state    <= soc_pkg::ST_REQ;
                  is_write <= 1'b0;
               end else if (!aw_rdy && !ar_rdy) begin
                  // write wins over a pending read
                  if (axil_req.awvalid && axil_req.wvalid)
                     aw_rdy <= 1'b1;
                  else if (axil_req.arvalid)
                     ar_rdy <= 1'b1;
               end
            end
            // native request held until the slave answers
            soc_pkg::ST_REQ: begin
               if (nat_rsp.ready)
                  state <= is_write ? soc_pkg::ST_WRSP : soc_pkg::ST_RRSP;
            end
            soc_pkg::ST_WRSP: begin
               if (axil_req.bready)
                  state <= soc_pkg::ST_IDLE;
            end
            default: begin
               if (axil_req.rready)
                  state <= soc_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // payload capture
   always_ff @(posedge clk) begin
      if (aw_fire) begin
         req_addr.raw <= axil_req.awaddr;
         req_wdata    <= axil_req.wdata;
         req_wstrb    <= axil_req.wstrb;
      end else if (ar_fire) begin
         req_addr.raw <= axil_req.araddr;
         req_wdata    <= '0;
         req_wstrb    <= '0;
      end
      if (state == soc_pkg::ST_REQ && nat_rsp.ready)
         rsp_rdata <= nat_rsp.rdata;
   end

   ////////////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////////////
   assign nat_req.valid = (state == soc_pkg::ST_REQ);
   assign nat_req.addr  = req_addr;
   assign nat_req.wdata = req_wdata;
   assign nat_req.wstrb = req_wstrb;

   // aw and w always taken together
   assign axil_rsp.awready = aw_rdy;
   assign axil_rsp.wready  = aw_rdy;
   assign axil_rsp.arready = ar_rdy;
   assign axil_rsp.bvalid  = (state == soc_pkg::ST_WRSP);
   assign axil_rsp.bresp   = soc_pkg::RESP_OKAY;
   assign axil_rsp.rvalid  = (state == soc_pkg::ST_RRSP);
   assign axil_rsp.rdata   = rsp_rdata;
   assign axil_rsp.rresp   = soc_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// ==== hdl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   ////////////////////////////////////////////////////////////////////
   // basic bus types
   ////////////////////////////////////////////////////////////////////
   typedef logic [31:0] word_t;
   typedef logic [3:0]  strb_t;

   // address word as seen by the slaves
   typedef struct packed {
      logic [1:0]  region;
      logic [15:0] unused;
      logic [11:0] word_index;
      logic [1:0]  byte_offset;
   } soc_addr_s;

   // same word, raw or decoded
   typedef union packed {
      word_t     raw;
      soc_addr_s f;
   } soc_addr_u;

   // native bus, zero wstrb is a read
   typedef struct packed {
      logic      valid;
      soc_addr_u addr;
      word_t     wdata;
      strb_t     wstrb;
   } nat_req_t;

   typedef struct packed {
      logic  ready;
      word_t rdata;
   } nat_rsp_t;

   // axi4-lite, master side
   typedef struct packed {
      logic  awvalid;
      word_t awaddr;
      logic  wvalid;
      word_t wdata;
      strb_t wstrb;
      logic  bready;
      logic  arvalid;
      word_t araddr;
      logic  rready;
   } axil_req_t;

   // axi4-lite, slave side
   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
      logic       arready;
      logic       rvalid;
      word_t      rdata;
      logic [1:0] rresp;
   } axil_rsp_t;

   ////////////////////////////////////////////////////////////////////
   // address map and system constants
   ////////////////////////////////////////////////////////////////////
   localparam logic [1:0] REGION_CODE = 2'd0;
   localparam logic [1:0] REGION_MAIN = 2'd1;
   localparam logic [1:0] REGION_UART = 2'd2;
   localparam logic [1:0] REGION_CTRL = 2'd3;

   localparam int BOOT_WORDS = 1024;
   localparam int MAIN_WORDS = 4096;

   localparam int POR_CYCLES        = 16;
   localparam int CORE_RESET_CYCLES = 4;

   localparam word_t CTRL_REMAP_ADDR = 32'hFFFF_FFFC;

   // uart register map, byte offsets
   localparam logic [15:0] UART_DIV_RESET = 16'd8;
   localparam logic [3:0]  UART_DATA      = 4'h0;
   localparam logic [3:0]  UART_DIV       = 4'h4;
   localparam logic [3:0]  UART_STAT      = 4'h8;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // bridge fsm encoding
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_REQ  = 2'd1;
   localparam logic [1:0] ST_WRSP = 2'd2;
   localparam logic [1:0] ST_RRSP = 2'd3;

endpackage

`default_nettype wire
